//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rv_core_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- design/decode_stage.sv
`include "rv_consts.svh"

module decode_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  instr_valid,
    input  logic [31:0]           instr,
    input  logic                  stall,
    output logic [`RV_REG_AW-1:0] rs1_idx,
    output logic [`RV_REG_AW-1:0] rs2_idx,
    output logic                  use_rs1,
    output logic                  use_rs2,
    input  logic [`RV_XLEN-1:0]   rs1_data,
    input  logic [`RV_XLEN-1:0]   rs2_data,
    output logic                  ex_valid,
    output rv_isa_pkg::opcode_e   ex_opcode,
    output rv_isa_pkg::alu_fn_e   ex_fn,
    output logic                  ex_alt,
    output logic [`RV_XLEN-1:0]   ex_imm,
    output logic [`RV_REG_AW-1:0] ex_rs1,
    output logic [`RV_REG_AW-1:0] ex_rs2,
    output logic [`RV_XLEN-1:0]   ex_rs1_data,
    output logic [`RV_XLEN-1:0]   ex_rs2_data,
    output logic [`RV_REG_AW-1:0] ex_rd,
    output logic                  ex_wr_en
);
    import rv_isa_pkg::*;

    logic [31:0]         held_instr;
    logic                held_valid;
    opcode_e             opcode;
    alu_fn_e             fn;
    logic                alt;
    logic                wr_en;
    logic [`RV_XLEN-1:0] imm;

    // Held instruction stays put while stalled
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            held_valid <= 1'b0;
        end
        else if (!stall)
        begin
            held_valid <= instr_valid; // Gap becomes a bubble
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall && instr_valid)
        begin
            held_instr <= instr;
        end
    end

    assign rs1_idx = held_instr[19:15];
    assign rs2_idx = held_instr[24:20];
    assign opcode  = held_valid ? opcode_e'(held_instr[6:0]) : OP_NONE;

    always_comb
    begin
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        wr_en   = 1'b0;
        alt     = 1'b0;
        fn      = alu_fn_e'(held_instr[14:12]);
        imm     = {{(`RV_XLEN-12){held_instr[31]}}, held_instr[31:20]}; // I-type
        case (opcode)
            OP_ALU_RR:
            begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                wr_en   = 1'b1;
                alt     = held_instr[30];
            end
            OP_ALU_IMM:
            begin
                use_rs1 = 1'b1;
                wr_en   = 1'b1;
                alt     = (fn == FN_SR) && held_instr[30]; // Only SRAI
            end
            OP_LOAD:
            begin
                use_rs1 = 1'b1;
                wr_en   = 1'b1;
                fn      = FN_ADD; // Address add
            end
            OP_STORE:
            begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                fn      = FN_ADD;
                imm     = {{(`RV_XLEN-12){held_instr[31]}}, held_instr[31:25],
                           held_instr[11:7]};
            end
            default:
            begin
                // Bubble or unsupported opcode, no side effects
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ex_valid  <= 1'b0;
            ex_opcode <= OP_NONE;
            ex_wr_en  <= 1'b0;
        end
        else if (stall)
        begin
            ex_valid  <= 1'b0; // Insert bubble
            ex_opcode <= OP_NONE;
            ex_wr_en  <= 1'b0;
        end
        else
        begin
            ex_valid  <= held_valid;
            ex_opcode <= opcode;
            ex_wr_en  <= wr_en;
        end
    end

    always_ff @(posedge clk)
    begin
        ex_fn       <= fn;
        ex_alt      <= alt;
        ex_imm      <= imm;
        ex_rs1      <= rs1_idx;
        ex_rs2      <= rs2_idx;
        ex_rs1_data <= rs1_data;
        ex_rs2_data <= rs2_data;
        ex_rd       <= held_instr[11:7];
    end

endmodule

//--- design/exec_stage.sv
`include "rv_consts.svh"

module exec_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  ex_valid,
    input  rv_isa_pkg::opcode_e   ex_opcode,
    input  rv_isa_pkg::alu_fn_e   ex_fn,
    input  logic                  ex_alt,
    input  logic [`RV_XLEN-1:0]   ex_imm,
    input  logic [`RV_XLEN-1:0]   ex_rs1_data,
    input  logic [`RV_XLEN-1:0]   ex_rs2_data,
    input  logic [`RV_REG_AW-1:0] ex_rd,
    input  logic                  ex_wr_en,
    input  rv_pipe_pkg::fwd_sel_e fwd_rs1,
    input  rv_pipe_pkg::fwd_sel_e fwd_rs2,
    input  logic [`RV_XLEN-1:0]   wb_wr_data,
    output logic                  mem_valid,
    output logic                  mem_is_load,
    output logic                  mem_is_store,
    output logic [`RV_XLEN-1:0]   mem_result,
    output logic [`RV_XLEN-1:0]   mem_store_data,
    output logic [`RV_REG_AW-1:0] mem_rd,
    output logic                  mem_wr_en
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] sra_out;
    logic [`RV_XLEN-1:0] alu_out;

    function automatic logic [`RV_XLEN-1:0] fwd_mux(
        input fwd_sel_e            sel,
        input logic [`RV_XLEN-1:0] reg_val,
        input logic [`RV_XLEN-1:0] mem_val,
        input logic [`RV_XLEN-1:0] wb_val
    );
        case (sel)
            FWD_MEM: fwd_mux = mem_val;
            FWD_WB:  fwd_mux = wb_val;
            default: fwd_mux = reg_val;
        endcase
    endfunction

    assign op_a    = fwd_mux(fwd_rs1, ex_rs1_data, mem_result, wb_wr_data);
    assign rs2_val = fwd_mux(fwd_rs2, ex_rs2_data, mem_result, wb_wr_data);
    assign op_b    = (ex_opcode == OP_ALU_RR) ? rs2_val : ex_imm;
    assign shamt   = op_b[4:0];
    assign sra_out = $signed(op_a) >>> shamt;

    always_comb
    begin
        case (ex_fn)
            FN_ADD:  alu_out = ex_alt ? op_a - op_b : op_a + op_b;
            FN_SLL:  alu_out = op_a << shamt;
            FN_SLT:  alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            FN_SLTU: alu_out = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            FN_XOR:  alu_out = op_a ^ op_b;
            FN_SR:   alu_out = ex_alt ? sra_out : op_a >> shamt;
            FN_OR:   alu_out = op_a | op_b;
            FN_AND:  alu_out = op_a & op_b;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mem_valid    <= 1'b0;
            mem_is_load  <= 1'b0;
            mem_is_store <= 1'b0;
            mem_wr_en    <= 1'b0;
        end
        else
        begin
            mem_valid    <= ex_valid;
            mem_is_load  <= ex_valid && ex_opcode == OP_LOAD;
            mem_is_store <= ex_valid && ex_opcode == OP_STORE;
            mem_wr_en    <= ex_valid && ex_wr_en;
        end
    end

    always_ff @(posedge clk)
    begin
        mem_result     <= alu_out; // Also the load/store address
        mem_store_data <= rs2_val;
        mem_rd         <= ex_rd;
    end

endmodule

//--- design/hazard_unit.sv
`include "rv_consts.svh"

module hazard_unit (
    input  logic                  [`RV_REG_AW-1:0] rs1_idx,
    input  logic                  [`RV_REG_AW-1:0] rs2_idx,
    input  logic                  use_rs1,
    input  logic                  use_rs2,
    input  logic                  [`RV_REG_AW-1:0] ex_rs1,
    input  logic                  [`RV_REG_AW-1:0] ex_rs2,
    input  logic                  [`RV_REG_AW-1:0] ex_rd,
    input  logic                  ex_is_load,
    input  logic                  [`RV_REG_AW-1:0] mem_rd,
    input  logic                  mem_wr_en,
    input  logic                  [`RV_REG_AW-1:0] wb_rd,
    input  logic                  wb_valid,
    output rv_pipe_pkg::fwd_sel_e fwd_rs1,
    output rv_pipe_pkg::fwd_sel_e fwd_rs2,
    output logic                  stall
);
    import rv_pipe_pkg::*;

    // Nearest producer wins
    function automatic fwd_sel_e pick_src(
        input logic [`RV_REG_AW-1:0] src,
        input logic [`RV_REG_AW-1:0] m_rd,
        input logic                  m_wr,
        input logic [`RV_REG_AW-1:0] w_rd,
        input logic                  w_valid
    );
        if (m_wr && m_rd != '0 && m_rd == src)
            pick_src = FWD_MEM;
        else if (w_valid && w_rd == src) // wb_valid already excludes x0
            pick_src = FWD_WB;
        else
            pick_src = FWD_REG;
    endfunction

    assign fwd_rs1 = pick_src(ex_rs1, mem_rd, mem_wr_en, wb_rd, wb_valid);
    assign fwd_rs2 = pick_src(ex_rs2, mem_rd, mem_wr_en, wb_rd, wb_valid);

    // One bubble lets the write-back forward catch the load data
    assign stall = ex_is_load && ex_rd != '0 &&
                   ((use_rs1 && rs1_idx == ex_rd) || (use_rs2 && rs2_idx == ex_rd));

endmodule

//--- design/mem_stage.sv
`include "rv_consts.svh"

module mem_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  mem_valid,
    input  logic                  mem_is_load,
    input  logic                  mem_is_store,
    input  logic [`RV_XLEN-1:0]   mem_result,
    input  logic [`RV_XLEN-1:0]   mem_store_data,
    input  logic [`RV_REG_AW-1:0] mem_rd,
    input  logic                  mem_wr_en,
    output logic                  wb_valid,
    output logic [`RV_REG_AW-1:0] wb_rd,
    output logic [`RV_XLEN-1:0]   wb_wr_data
);
    logic [`RV_XLEN-1:0]    dmem [`RV_DMEM_WORDS];
    logic [`RV_DMEM_AW-1:0] addr;
    logic [`RV_XLEN-1:0]    rd_word;

    assign addr    = mem_result[`RV_DMEM_AW+1:2]; // Word address
    assign rd_word = dmem[addr];

    always_ff @(posedge clk)
    begin
        if (mem_valid && mem_is_store)
        begin
            dmem[addr] <= mem_store_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= mem_valid && mem_wr_en && mem_rd != '0;
    end

    always_ff @(posedge clk)
    begin
        wb_rd      <= mem_rd;
        wb_wr_data <= mem_is_load ? rd_word : mem_result;
    end

endmodule

//--- design/reg_file.sv
`include "rv_consts.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [`RV_REG_AW-1:0] rs1_idx,
    input  logic [`RV_REG_AW-1:0] rs2_idx,
    output logic [`RV_XLEN-1:0]   rs1_data,
    output logic [`RV_XLEN-1:0]   rs2_data,
    input  logic                  wr_en,
    input  logic [`RV_REG_AW-1:0] wr_idx,
    input  logic [`RV_XLEN-1:0]   wr_data
);
    localparam int NREGS = 1 << `RV_REG_AW;

    logic [`RV_XLEN-1:0]   regs    [1:NREGS-1]; // x0 not stored
    logic [`RV_REG_AW-1:0] rd_idx  [2];
    logic [`RV_XLEN-1:0]   rd_data [2];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 1; i < NREGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && wr_idx != '0)
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rd_idx[0] = rs1_idx;
    assign rd_idx[1] = rs2_idx;

    // Same-cycle write is passed through
    always_comb
    begin
        for (int p = 0; p < 2; p++)
        begin
            if (rd_idx[p] == '0)
                rd_data[p] = '0;
            else if (wr_en && wr_idx == rd_idx[p])
                rd_data[p] = wr_data;
            else
                rd_data[p] = regs[rd_idx[p]];
        end
    end

    assign rs1_data = rd_data[0];
    assign rs2_data = rd_data[1];

endmodule

//--- design/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data path word width
`define RV_XLEN 32

// Register index width, 32 architectural registers
`define RV_REG_AW 5

// Word-addressed data memory
`define RV_DMEM_WORDS 256
`define RV_DMEM_AW 8

`endif

//--- design/rv_core.sv
`include "rv_consts.svh"

module rv_core (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  instr_valid,
    input  logic [31:0]           instr,
    output logic                  stall,
    output logic                  wb_valid,
    output logic [`RV_REG_AW-1:0] wb_rd,
    output logic [`RV_XLEN-1:0]   wb_data
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    // Decode side
    logic [`RV_REG_AW-1:0] rs1_idx;
    logic [`RV_REG_AW-1:0] rs2_idx;
    logic                  use_rs1;
    logic                  use_rs2;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;

    // Decode-to-execute register
    logic                  ex_valid;
    opcode_e               ex_opcode;
    alu_fn_e               ex_fn;
    logic                  ex_alt;
    logic [`RV_XLEN-1:0]   ex_imm;
    logic [`RV_REG_AW-1:0] ex_rs1;
    logic [`RV_REG_AW-1:0] ex_rs2;
    logic [`RV_XLEN-1:0]   ex_rs1_data;
    logic [`RV_XLEN-1:0]   ex_rs2_data;
    logic [`RV_REG_AW-1:0] ex_rd;
    logic                  ex_wr_en;

    // Execute-to-memory register
    logic                  mem_valid;
    logic                  mem_is_load;
    logic                  mem_is_store;
    logic [`RV_XLEN-1:0]   mem_result;
    logic [`RV_XLEN-1:0]   mem_store_data;
    logic [`RV_REG_AW-1:0] mem_rd;
    logic                  mem_wr_en;

    fwd_sel_e              fwd_rs1;
    fwd_sel_e              fwd_rs2;

    decode_stage u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .use_rs1     (use_rs1),
        .use_rs2     (use_rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .ex_valid    (ex_valid),
        .ex_opcode   (ex_opcode),
        .ex_fn       (ex_fn),
        .ex_alt      (ex_alt),
        .ex_imm      (ex_imm),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .ex_rs1_data (ex_rs1_data),
        .ex_rs2_data (ex_rs2_data),
        .ex_rd       (ex_rd),
        .ex_wr_en    (ex_wr_en)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb_valid),
        .wr_idx   (wb_rd),
        .wr_data  (wb_data)
    );

    exec_stage u_exec (
        .clk            (clk),
        .arst_n         (arst_n),
        .ex_valid       (ex_valid),
        .ex_opcode      (ex_opcode),
        .ex_fn          (ex_fn),
        .ex_alt         (ex_alt),
        .ex_imm         (ex_imm),
        .ex_rs1_data    (ex_rs1_data),
        .ex_rs2_data    (ex_rs2_data),
        .ex_rd          (ex_rd),
        .ex_wr_en       (ex_wr_en),
        .fwd_rs1        (fwd_rs1),
        .fwd_rs2        (fwd_rs2),
        .wb_wr_data     (wb_data),
        .mem_valid      (mem_valid),
        .mem_is_load    (mem_is_load),
        .mem_is_store   (mem_is_store),
        .mem_result     (mem_result),
        .mem_store_data (mem_store_data),
        .mem_rd         (mem_rd),
        .mem_wr_en      (mem_wr_en)
    );

    mem_stage u_mem (
        .clk            (clk),
        .arst_n         (arst_n),
        .mem_valid      (mem_valid),
        .mem_is_load    (mem_is_load),
        .mem_is_store   (mem_is_store),
        .mem_result     (mem_result),
        .mem_store_data (mem_store_data),
        .mem_rd         (mem_rd),
        .mem_wr_en      (mem_wr_en),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_wr_data     (wb_data)
    );

    // A load in the memory stage has no ALU result worth forwarding
    hazard_unit u_hazard (
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .use_rs1    (use_rs1),
        .use_rs2    (use_rs2),
        .ex_rs1     (ex_rs1),
        .ex_rs2     (ex_rs2),
        .ex_rd      (ex_rd),
        .ex_is_load (ex_opcode == OP_LOAD),
        .mem_rd     (mem_rd),
        .mem_wr_en  (mem_wr_en && !mem_is_load),
        .wb_rd      (wb_rd),
        .wb_valid   (wb_valid),
        .fwd_rs1    (fwd_rs1),
        .fwd_rs2    (fwd_rs2),
        .stall      (stall)
    );

endmodule

//--- design/rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP_NONE    = 7'b0000000, // Bubble
        OP_LOAD    = 7'b0000011, // LW
        OP_ALU_IMM = 7'b0010011, // ADDI .. SRAI
        OP_STORE   = 7'b0100011, // SW
        OP_ALU_RR  = 7'b0110011  // ADD .. AND
    } opcode_e;

    // ALU function, straight from funct3
    // Add/sub and the two right shifts are split by funct7 bit 5
    typedef enum logic [2:0] {
        FN_ADD  = 3'b000,
        FN_SLL  = 3'b001,
        FN_SLT  = 3'b010,
        FN_SLTU = 3'b011,
        FN_XOR  = 3'b100,
        FN_SR   = 3'b101, // SRL or SRA
        FN_OR   = 3'b110,
        FN_AND  = 3'b111
    } alu_fn_e;

endpackage

//--- design/rv_pipe_pkg.sv
package rv_pipe_pkg;

    // Where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_REG = 2'd0, // Register file value latched in decode
        FWD_MEM = 2'd1, // ALU result in the execute-to-memory register
        FWD_WB  = 2'd2  // Value in the memory-to-write-back register
    } fwd_sel_e;

endpackage

//--- filelist.f
+incdir+design
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/reg_file.sv
design/decode_stage.sv
design/exec_stage.sv
design/mem_stage.sv
design/hazard_unit.sv
design/rv_core.sv
tb/tb_clk_gen.sv
tb/rv_core_tb.sv

//--- tb/rv_core_tb.sv
`include "rv_consts.svh"

module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_isa_pkg::*;

    localparam int          N_INIT         = 16; // One store per data word used
    localparam int          N_RAND         = 400;
    localparam int          PROG_LEN       = N_INIT + N_RAND;
    localparam int          TIMEOUT_CYCLES = 3 * PROG_LEN + 100;
    localparam int          DRAIN_CYCLES   = 6; // Pipeline depth plus one stall
    localparam logic [31:0] SEED           = 32'he6bf_5153;

    logic                  clk;
    logic                  arst_n;
    logic                  instr_valid;
    logic [31:0]           instr;
    logic                  stall;
    logic                  wb_valid;
    logic [`RV_REG_AW-1:0] wb_rd;
    logic [`RV_XLEN-1:0]   wb_data;

    logic [31:0]           lfsr;
    int                    issued;
    int                    accepted;
    int                    cycles;
    int                    stall_cnt;
    int                    post_rst;
    logic                  stall_s;    // stall as seen before the next edge
    logic                  stall_prev;
    logic [31:0]           ref_regs [32];
    logic [31:0]           ref_mem  [16];
    logic [`RV_REG_AW-1:0] exp_rd   [$];
    logic [`RV_XLEN-1:0]   exp_data [$];

    tb_clk_gen clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    rv_core UUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
        fail_run($sformatf("error at %0d ns: %s expected 0x%08h, got 0x%08h",
                           $time, name, exp, got));
    endtask

    // Galois form, right shift
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            lfsr_next = (s >> 1) ^ 32'h8020_0003;
        else
            lfsr_next = s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // RV32I semantics, written out from the spec
    function automatic logic [31:0] alu_ref(input alu_fn_e fn, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (fn)
            FN_ADD:  alu_ref = alt ? a + ~b + 32'd1 : a + b;
            FN_SLL:  alu_ref = a << sh;
            FN_SLT:  alu_ref = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            FN_SLTU: alu_ref = {31'd0, a < b};
            FN_XOR:  alu_ref = a ^ b;
            FN_SR:   alu_ref = (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'd0);
            FN_OR:   alu_ref = a | b;
            default: alu_ref = a & b;
        endcase
    endfunction

    task automatic apply_ref(input logic [31:0] ins);
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] addr;
        logic [31:0] val;
        logic        writes;
        rd     = ins[11:7];
        a      = ref_regs[ins[19:15]];
        b      = ref_regs[ins[24:20]];
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        imm_s  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        val    = '0;
        writes = 1'b1;
        case (ins[6:0])
            OP_ALU_RR:
                val = alu_ref(alu_fn_e'(ins[14:12]), ins[30], a, b);
            OP_ALU_IMM:
                val = alu_ref(alu_fn_e'(ins[14:12]),
                              alu_fn_e'(ins[14:12]) == FN_SR && ins[30], a, imm_i);
            OP_LOAD:
            begin
                addr = a + imm_i;
                val  = ref_mem[addr[5:2]];
            end
            default:
            begin
                addr              = a + imm_s; // SW
                ref_mem[addr[5:2]] = b;
                writes            = 1'b0;
            end
        endcase
        if (writes && rd != 5'd0)
        begin
            ref_regs[rd] = val;
            exp_rd.push_back(rd);
            exp_data.push_back(val);
        end
    endtask

    task automatic make_instr(output logic [31:0] ins);
        logic [31:0] kind;
        logic [31:0] f3;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] word;
        logic [31:0] alt;
        logic [31:0] imm;
        logic [11:0] off;
        logic [11:0] imm12;
        logic        alt_rr;
        if (issued < N_INIT)
        begin
            take_bits(3, rs2);
            off = {6'd0, 4'(issued), 2'b00};
            ins = {off[11:5], rs2[4:0], 5'd0, 3'b010, off[4:0], OP_STORE};
        end
        else
        begin
            take_bits(3, kind);
            take_bits(3, f3);
            take_bits(3, rd);  // x0..x7 keeps dependencies close
            take_bits(3, rs1);
            take_bits(3, rs2);
            take_bits(4, word);
            take_bits(1, alt);
            take_bits(12, imm);
            off    = {6'd0, word[3:0], 2'b00};
            alt_rr = (f3[2:0] == FN_ADD || f3[2:0] == FN_SR) && alt[0];
            if (f3[2:0] == FN_SLL)
                imm12 = {7'd0, imm[4:0]};
            else if (f3[2:0] == FN_SR)
                imm12 = {1'b0, alt[0], 5'd0, imm[4:0]}; // SRLI or SRAI
            else
                imm12 = imm[11:0];
            case (kind[2:0])
                3'd0, 3'd1, 3'd2:
                    ins = {1'b0, alt_rr, 5'd0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_ALU_RR};
                3'd3, 3'd4, 3'd5:
                    ins = {imm12, rs1[4:0], f3[2:0], rd[4:0], OP_ALU_IMM};
                3'd6:
                    ins = {off, 5'd0, 3'b010, rd[4:0], OP_LOAD};
                default:
                    ins = {off[11:5], rs2[4:0], 5'd0, 3'b010, off[4:0], OP_STORE};
            endcase
        end
    endtask

    task automatic present_next();
        logic [31:0] g;
        logic [31:0] ins;
        take_bits(2, g);
        if (issued >= PROG_LEN || g[1:0] == 2'b00)
        begin
            instr_valid <= 1'b0; // Gap
        end
        else
        begin
            make_instr(ins);
            instr       <= ins;
            instr_valid <= 1'b1;
            issued++;
        end
    endtask

    always @(posedge clk)
    begin
        if (arst_n && !stall_s)
        begin
            if (instr_valid)
            begin
                apply_ref(instr);
                accepted++;
            end
            present_next();
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk)
    begin
        if (cycles > 0)
        begin
            stall_prev = stall_s;
            stall_s    = stall;
            if (post_rst == 0)
            begin
                assert (!wb_valid && !stall)
                else fail_run("wb_valid or stall was high during or right after reset");
            end
            if (arst_n)
                post_rst++;
            assert (!(stall && stall_prev))
            else fail_run("stall stayed high for more than one cycle");
            if (stall)
                stall_cnt++;
            if (wb_valid)
            begin
                assert (exp_rd.size() > 0)
                else fail_run("write-back strobe with no register write pending");
                assert (wb_rd == exp_rd[0])
                else value_error("wb_rd", 32'(exp_rd[0]), 32'(wb_rd));
                assert (wb_data == exp_data[0])
                else value_error("wb_data", exp_data[0], wb_data);
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
            fail_run($sformatf("timeout after %0d cycles, %0d of %0d instructions accepted",
                               TIMEOUT_CYCLES, accepted, PROG_LEN));
    end

    initial
    begin
        instr_valid = 1'b0;
        instr       = '0;
        lfsr        = SEED;
        issued      = 0;
        accepted    = 0;
        cycles      = 0;
        stall_cnt   = 0;
        post_rst    = 0;
        stall_s     = 1'b0;
        stall_prev  = 1'b0;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = '0;
        for (int i = 0; i < 16; i++)
            ref_mem[i] = '0;

        wait (accepted == PROG_LEN);
        repeat (DRAIN_CYCLES) @(posedge clk);

        if (exp_rd.size() == 0 && stall_cnt > 0)
        begin
            $display("PASS: all tests");
            $finish;
        end
        else if (exp_rd.size() != 0)
        begin
            fail_run($sformatf("%0d expected write-backs never arrived", exp_rd.size()));
        end
        else
        begin
            fail_run("no load-use stall was seen during the run");
        end
    end

endmodule

//--- tb/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 5; // 10 ns clock
    localparam int RESET_CYCLES = 8;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial
    begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1; // Released on a rising edge
    end

endmodule
